//--- sim.f
+incdir+tests
hdl/priv_pkg.sv
hdl/isa_pkg.sv
hdl/insn_decoder.sv
hdl/mstatus_checker.sv
hdl/legality_checker.sv
hdl/retire_ctrl.sv
hdl/umode_monitor.sv
tests/tb_umode_monitor.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_umode_monitor -f sim.f \
  && ./obj_dir/Vtb_umode_monitor > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "FAILED"; exit 1; }
grep -q "Test passed" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "PASSED"

//--- tests/monitor_model.svh
// expected monitor state, carried from one retirement to the next
logic                        model_first;
logic                        model_trap;
logic                        model_mret;
logic [priv_pkg::MODE_W-1:0] model_exp_mode;

function automatic void clear_model();
  model_first    = 1'b1;
  model_trap     = 1'b0;
  model_mret     = 1'b0;
  model_exp_mode = priv_pkg::MODE_M;
endfunction

// flags for one retirement, then the expectations for the next one
function automatic logic [priv_pkg::FLAGS_W-1:0] predict_flags(
  input logic [priv_pkg::MODE_W-1:0] mode,
  input logic [31:0]                 insn,
  input logic                        exc,
  input logic [isa_pkg::CAUSE_W-1:0] cause,
  input logic [31:0]                 rdata,
  input logic [31:0]                 wdata,
  input logic [31:0]                 wmask,
  input logic [31:0]                 cnten
);
  logic [priv_pkg::FLAGS_W-1:0] f;
  logic [31:0]                  post;
  logic [11:0]                  addr;
  logic                         in_u;
  logic                         csr;
  logic                         high;
  logic                         must_trap;
  int                           idx;
  f    = '0;
  in_u = (mode == priv_pkg::MODE_U);
  addr = insn[31:20];
  post = (wdata & wmask) | (rdata & ~wmask);
  csr  = (insn[6:0] == isa_pkg::SYSTEM_OPCODE) && !(insn[14:12] inside {3'd0, 3'd4});
  idx  = int'(addr) - int'(priv_pkg::CSRADDR_HPM0);
  high = cause inside {isa_pkg::EXC_CAUSE_INSTR_FAULT, isa_pkg::EXC_CAUSE_INSTR_BUS_FAULT,
                       isa_pkg::EXC_CAUSE_INSTR_INTEGRITY_FAULT};
  must_trap = (insn == isa_pkg::URET_IDATA) ||
              ((insn == isa_pkg::MRET_IDATA) && in_u) ||
              ((insn == isa_pkg::WFI_IDATA) && in_u && rdata[priv_pkg::TW_POS]) ||
              ((insn != isa_pkg::WFE_IDATA) && ((insn & isa_pkg::CUSTOM_IMASK) inside
                {isa_pkg::CUSTOM0_IDATA, isa_pkg::CUSTOM1_IDATA})) ||
              (csr && in_u && (addr[9:8] != priv_pkg::MODE_U)) ||
              (csr && (addr inside {priv_pkg::CSRADDR_MEDELEG, priv_pkg::CSRADDR_MIDELEG})) ||
              (csr && (addr inside {priv_pkg::CSRADDR_USTATUS, priv_pkg::CSRADDR_UIE,
                priv_pkg::CSRADDR_UTVEC, priv_pkg::CSRADDR_USCRATCH, priv_pkg::CSRADDR_UEPC,
                priv_pkg::CSRADDR_UCAUSE, priv_pkg::CSRADDR_UTVAL, priv_pkg::CSRADDR_UIP}));
  // user counter with its mcounteren bit clear
  if (csr && in_u && (idx >= 0) && (idx < priv_pkg::HPM_COUNT) && !cnten[idx]) begin
    must_trap = 1'b1;
  end
  f[priv_pkg::FLAG_BAD_MODE]    = !(mode inside {priv_pkg::MODE_M, priv_pkg::MODE_U});
  f[priv_pkg::FLAG_RESET_MODE]  = model_first && (mode != priv_pkg::MODE_M);
  f[priv_pkg::FLAG_TRAP_TARGET] = model_trap && (mode != priv_pkg::MODE_M);
  f[priv_pkg::FLAG_MRET_TARGET] = model_mret && (mode != model_exp_mode);
  f[priv_pkg::FLAG_MSTATUS_FIELD] =
    !(post[priv_pkg::MPP_POS +: priv_pkg::MPP_LEN] inside {priv_pkg::MODE_M, priv_pkg::MODE_U}) ||
    rdata[priv_pkg::SPP_POS] || rdata[priv_pkg::SD_POS] ||
    (|rdata[priv_pkg::XS_POS +: priv_pkg::XS_LEN]) ||
    (|rdata[priv_pkg::FS_POS +: priv_pkg::FS_LEN]) || (in_u && rdata[priv_pkg::MPRV_POS]);
  f[priv_pkg::FLAG_MRET_WRITE] = (insn == isa_pkg::MRET_IDATA) && !exc &&
    ((post[priv_pkg::MPP_POS +: priv_pkg::MPP_LEN] != priv_pkg::MODE_U) ||
     ((rdata[priv_pkg::MPP_POS +: priv_pkg::MPP_LEN] == priv_pkg::MODE_U) &&
      post[priv_pkg::MPRV_POS]));
  f[priv_pkg::FLAG_NOT_ILLEGAL] = must_trap &&
    !(exc && (high || (cause == isa_pkg::EXC_CAUSE_ILLEGAL_INSN)));
  f[priv_pkg::FLAG_ECALL_CAUSE] = (insn == isa_pkg::ECALL_IDATA) && in_u &&
    !(exc && (high || (cause inside {isa_pkg::EXC_CAUSE_ILLEGAL_INSN,
                                     isa_pkg::EXC_CAUSE_ECALL_UMODE})));
  model_first = 1'b0;
  model_trap  = exc;
  model_mret  = (insn == isa_pkg::MRET_IDATA) && !exc && (mode == priv_pkg::MODE_M);
  if (model_mret) begin
    model_exp_mode = rdata[priv_pkg::MPP_POS +: priv_pkg::MPP_LEN];
  end
  return f;
endfunction

//--- tests/tb_umode_monitor.sv
module tb_umode_monitor;

  localparam int RESET_CYCLES  = 16;
  localparam int SHORT_RUNS    = 6;
  localparam int TOTAL_STROBES = SHORT_RUNS * 3 + 300 + 200;
  // a strobe takes at most 4 cycles
  // each test adds a reset and a drain
  localparam int CYCLE_LIMIT   = TOTAL_STROBES * 4 + (SHORT_RUNS + 2) * (RESET_CYCLES + 4) + 200;
  // mstatus fields a real core touches
  localparam logic [31:0] FIELD_MASK = (32'd1 << priv_pkg::TW_POS) |
    (32'd1 << priv_pkg::MPRV_POS) | (32'd3 << priv_pkg::MPP_POS);

  logic                         clk_i = 1'b0;
  logic                         reset;
  logic                         retire_valid;
  logic [priv_pkg::MODE_W-1:0]  retire_mode;
  logic [priv_pkg::XLEN-1:0]    retire_insn;
  logic                         trap_exception;
  logic [isa_pkg::CAUSE_W-1:0]  trap_cause;
  logic [priv_pkg::XLEN-1:0]    mstatus_rdata;
  logic [priv_pkg::XLEN-1:0]    mstatus_wdata;
  logic [priv_pkg::XLEN-1:0]    mstatus_wmask;
  logic [priv_pkg::XLEN-1:0]    mcounteren_rdata;
  logic                         report_valid;
  logic [priv_pkg::FLAGS_W-1:0] report_flags;

  logic [priv_pkg::FLAGS_W-1:0] exp_q[$];
  logic [priv_pkg::FLAGS_W-1:0] exp_flags;
  logic                         expect_valid = 1'b0;
  int                           error_count = 0;
  int                           report_count = 0;
  int                           strobe_count = 0;
  int                           cycle_count = 0;

  `include "monitor_model.svh"

  umode_monitor dut0 (.*);

  initial begin
    forever #10 clk_i = ~clk_i;
  end

  // favors system encodings and CSR addresses around the checked ranges
  function automatic logic [31:0] pick_insn();
    logic [31:0] r;
    logic [11:0] addr;
    r    = $urandom();
    addr = r[31:20];
    case ($urandom_range(15, 0))
      0: return isa_pkg::MRET_IDATA;
      1: return isa_pkg::WFI_IDATA;
      2: return isa_pkg::WFE_IDATA;
      3: return isa_pkg::URET_IDATA;
      4: return isa_pkg::ECALL_IDATA;
      5: return isa_pkg::CUSTOM0_IDATA | (r & ~isa_pkg::CUSTOM_IMASK);
      6: return isa_pkg::CUSTOM1_IDATA | (r & ~isa_pkg::CUSTOM_IMASK);
      7, 8: addr = priv_pkg::CSRADDR_HPM0 + 12'($urandom_range(32, 0));
      9: addr = priv_pkg::CSRADDR_MEDELEG + 12'($urandom_range(1, 0));
      10: addr = priv_pkg::CSRADDR_USTATUS + 12'($urandom_range(5, 0));
      11: addr = priv_pkg::CSRADDR_USCRATCH + 12'($urandom_range(5, 0));
      12: return r;
      default: ;
    endcase
    return {addr, r[19:7], isa_pkg::SYSTEM_OPCODE};
  endfunction

  // idle cycles get random fields too
  task automatic drive_cycle(input logic valid);
    logic [priv_pkg::MODE_W-1:0] mode;
    logic [31:0]                 insn;
    logic                        exc;
    logic [isa_pkg::CAUSE_W-1:0] cause;
    logic [31:0]                 rdata;
    logic [31:0]                 wdata;
    logic [31:0]                 wmask;
    logic [31:0]                 cnten;
    mode  = ($urandom_range(3, 0) == 0) ? 2'($urandom_range(2, 1)) :
            (($urandom_range(1, 0) == 0) ? priv_pkg::MODE_M : priv_pkg::MODE_U);
    insn  = pick_insn();
    exc   = ($urandom_range(2, 0) == 0);
    cause = ($urandom_range(1, 0) == 0) ? 6'($urandom_range(26, 0)) :
            (($urandom_range(1, 0) == 0) ? isa_pkg::EXC_CAUSE_ILLEGAL_INSN :
                                           isa_pkg::EXC_CAUSE_ECALL_UMODE);
    rdata = $urandom() & (($urandom_range(3, 0) == 0) ? 32'hFFFF_FFFF : FIELD_MASK);
    wdata = $urandom() & FIELD_MASK;
    wmask = ($urandom_range(1, 0) == 0) ? ($urandom() & FIELD_MASK) : $urandom();
    cnten = $urandom();
    retire_valid     <= valid;
    retire_mode      <= mode;
    retire_insn      <= insn;
    trap_exception   <= exc;
    trap_cause       <= cause;
    mstatus_rdata    <= rdata;
    mstatus_wdata    <= wdata;
    mstatus_wmask    <= wmask;
    mcounteren_rdata <= cnten;
    if (valid) begin
      exp_q.push_back(predict_flags(mode, insn, exc, cause, rdata, wdata, wmask, cnten));
      strobe_count++;
    end
  endtask

  task automatic run_test(input string name, input int count, input int gap_max);
    int errors_before;
    int n;
    errors_before = error_count;
    @(posedge clk_i);
    reset <= 1'b1;
    // strobes during reset must not produce a report
    repeat (RESET_CYCLES) begin
      drive_cycle(1'b0);
      retire_valid <= ($urandom_range(1, 0) == 1);
      @(posedge clk_i);
    end
    reset <= 1'b0;
    clear_model();
    for (n = 0; n < count; n++) begin
      drive_cycle(1'b1);
      @(posedge clk_i);
      repeat ($urandom_range(gap_max, 0)) begin
        drive_cycle(1'b0);
        @(posedge clk_i);
      end
    end
    drive_cycle(1'b0);
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    $display("test %s: %0d strobes, %0d errors", name, count, error_count - errors_before);
  endtask

  // outputs sampled on the falling edge
  always @(negedge clk_i) begin
    assert (report_valid === expect_valid) else begin
      error_count++;
      if (expect_valid) begin
        $display("ERROR: no report one cycle after a retirement at time %0t", $time);
        exp_q.delete(0);
      end else begin
        $display("ERROR: report without a retirement at time %0t", $time);
      end
    end
    if ((report_valid === 1'b1) && expect_valid) begin
      exp_flags = exp_q.pop_front();
      report_count++;
      assert (report_flags === exp_flags) else begin
        error_count++;
        $display("FAIL at time %0t: report_flags %b, expected %b", $time, report_flags,
                 exp_flags);
      end
    end
    expect_valid = (retire_valid === 1'b1) && (reset === 1'b0);
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("ERROR: timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h9c03225c));
    reset = 1'b1;
    drive_cycle(1'b0);
    clear_model();
    repeat (SHORT_RUNS) run_test("first_after_reset", 3, 3);
    run_test("random_gaps", 300, 3);
    run_test("back_to_back", 200, 0);
    repeat (3) @(posedge clk_i);
    $display("done: %0d strobes, %0d reports, %0d errors", strobe_count, report_count,
             error_count);
    if ((error_count == 0) && (report_count == strobe_count)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hdl/umode_monitor.sv
module umode_monitor (
  input  logic                         clk_i,
  input  logic                         reset,
  input  logic                         retire_valid,
  input  logic [priv_pkg::MODE_W-1:0]  retire_mode,
  input  logic [priv_pkg::XLEN-1:0]    retire_insn,
  input  logic                         trap_exception,
  input  logic [isa_pkg::CAUSE_W-1:0]  trap_cause,
  input  logic [priv_pkg::XLEN-1:0]    mstatus_rdata,
  input  logic [priv_pkg::XLEN-1:0]    mstatus_wdata,
  input  logic [priv_pkg::XLEN-1:0]    mstatus_wmask,
  input  logic [priv_pkg::XLEN-1:0]    mcounteren_rdata,
  output logic                         report_valid,
  output logic [priv_pkg::FLAGS_W-1:0] report_flags
);

  logic                        is_mret;
  logic                        is_wfi;
  logic                        is_uret;
  logic                        is_custom;
  logic                        is_ecall;
  logic                        is_csr;
  logic                        csr_above_user;
  logic                        is_counter_csr;
  logic                        counter_disabled;
  logic                        is_deleg_csr;
  logic                        is_next_csr;
  logic [priv_pkg::MODE_W-1:0] mpp_pre;
  logic                        mstatus_bad;
  logic                        mret_write_bad;
  logic                        not_illegal;
  logic                        ecall_bad;

  insn_decoder decoder0 (
    .retire_valid(retire_valid), .retire_insn(retire_insn), .retire_mode(retire_mode),
    .mcounteren_rdata(mcounteren_rdata), .is_mret(is_mret), .is_wfi(is_wfi),
    .is_uret(is_uret), .is_custom(is_custom), .is_ecall(is_ecall), .is_csr(is_csr),
    .csr_above_user(csr_above_user), .is_counter_csr(is_counter_csr),
    .counter_disabled(counter_disabled), .is_deleg_csr(is_deleg_csr),
    .is_next_csr(is_next_csr)
  );

  mstatus_checker mstatus0 (
    .retire_mode(retire_mode), .mstatus_rdata(mstatus_rdata),
    .mstatus_wdata(mstatus_wdata), .mstatus_wmask(mstatus_wmask), .is_mret(is_mret),
    .trap_exception(trap_exception), .mpp_pre(mpp_pre), .mstatus_bad(mstatus_bad),
    .mret_write_bad(mret_write_bad)
  );

  legality_checker legality0 (
    .retire_mode(retire_mode), .trap_exception(trap_exception), .trap_cause(trap_cause),
    .mstatus_rdata(mstatus_rdata), .is_mret(is_mret), .is_wfi(is_wfi), .is_uret(is_uret),
    .is_custom(is_custom), .is_ecall(is_ecall), .is_csr(is_csr),
    .csr_above_user(csr_above_user), .is_counter_csr(is_counter_csr),
    .counter_disabled(counter_disabled), .is_deleg_csr(is_deleg_csr),
    .is_next_csr(is_next_csr), .not_illegal(not_illegal), .ecall_bad(ecall_bad)
  );

  retire_ctrl ctrl0 (
    .clk_i(clk_i), .reset(reset), .retire_valid(retire_valid), .retire_mode(retire_mode),
    .trap_exception(trap_exception), .is_mret(is_mret), .mpp_pre(mpp_pre),
    .mstatus_bad(mstatus_bad), .mret_write_bad(mret_write_bad),
    .not_illegal(not_illegal), .ecall_bad(ecall_bad), .report_valid(report_valid),
    .report_flags(report_flags)
  );

endmodule

//--- hdl/retire_ctrl.sv
module retire_ctrl (
  input  logic                         clk_i,
  input  logic                         reset,
  input  logic                         retire_valid,
  input  logic [priv_pkg::MODE_W-1:0]  retire_mode,
  input  logic                         trap_exception,
  input  logic                         is_mret,
  input  logic [priv_pkg::MODE_W-1:0]  mpp_pre,
  input  logic                         mstatus_bad,
  input  logic                         mret_write_bad,
  input  logic                         not_illegal,
  input  logic                         ecall_bad,
  output logic                         report_valid,
  output logic [priv_pkg::FLAGS_W-1:0] report_flags
);

  logic                         first_pending;
  logic                         trap_pending;
  logic                         mret_pending;
  logic [priv_pkg::MODE_W-1:0]  exp_mode;
  logic                         mret_taken;
  logic [priv_pkg::FLAGS_W-1:0] flags;

  // legal mret from M sets up a mode expectation
  assign mret_taken = is_mret && !trap_exception && (retire_mode == priv_pkg::MODE_M);

  always_comb begin
    flags = '0;
    flags[priv_pkg::FLAG_BAD_MODE] = (retire_mode != priv_pkg::MODE_M) &&
                                     (retire_mode != priv_pkg::MODE_U);
    flags[priv_pkg::FLAG_RESET_MODE]    = first_pending && (retire_mode != priv_pkg::MODE_M);
    flags[priv_pkg::FLAG_TRAP_TARGET]   = trap_pending && (retire_mode != priv_pkg::MODE_M);
    flags[priv_pkg::FLAG_MRET_TARGET]   = mret_pending && (retire_mode != exp_mode);
    flags[priv_pkg::FLAG_MSTATUS_FIELD] = mstatus_bad;
    flags[priv_pkg::FLAG_MRET_WRITE]    = mret_write_bad;
    flags[priv_pkg::FLAG_NOT_ILLEGAL]   = not_illegal;
    flags[priv_pkg::FLAG_ECALL_CAUSE]   = ecall_bad;
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      report_valid  <= 1'b0;
      report_flags  <= '0;
      first_pending <= 1'b1;
      trap_pending  <= 1'b0;
      mret_pending  <= 1'b0;
    end else begin
      report_valid <= retire_valid;
      // idle cycles keep the expectations
      if (retire_valid) begin
        report_flags  <= flags;
        first_pending <= 1'b0;
        trap_pending  <= trap_exception;
        mret_pending  <= mret_taken;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire_valid && mret_taken) begin
      exp_mode <= mpp_pre;
    end
  end

endmodule

//--- hdl/legality_checker.sv
module legality_checker (
  input  logic [priv_pkg::MODE_W-1:0] retire_mode,
  input  logic                        trap_exception,
  input  logic [isa_pkg::CAUSE_W-1:0] trap_cause,
  input  logic [priv_pkg::XLEN-1:0]   mstatus_rdata,
  input  logic                        is_mret,
  input  logic                        is_wfi,
  input  logic                        is_uret,
  input  logic                        is_custom,
  input  logic                        is_ecall,
  input  logic                        is_csr,
  input  logic                        csr_above_user,
  input  logic                        is_counter_csr,
  input  logic                        counter_disabled,
  input  logic                        is_deleg_csr,
  input  logic                        is_next_csr,
  output logic                        not_illegal,
  output logic                        ecall_bad
);

  logic in_u;
  logic higher_cause;
  logic illegal_raised;
  logic ecall_cause_ok;
  logic must_be_illegal;

  assign in_u = (retire_mode == priv_pkg::MODE_U);

  // fetch side faults outrank illegal-instruction
  assign higher_cause = (trap_cause == isa_pkg::EXC_CAUSE_INSTR_FAULT) ||
                        (trap_cause == isa_pkg::EXC_CAUSE_INSTR_BUS_FAULT) ||
                        (trap_cause == isa_pkg::EXC_CAUSE_INSTR_INTEGRITY_FAULT);

  assign illegal_raised = trap_exception &&
                          ((trap_cause == isa_pkg::EXC_CAUSE_ILLEGAL_INSN) || higher_cause);

  assign must_be_illegal = (is_mret && in_u) ||
                           (is_wfi && in_u && mstatus_rdata[priv_pkg::TW_POS]) ||
                           is_uret ||
                           is_custom ||
                           (is_csr && in_u && csr_above_user) ||
                           (is_counter_csr && counter_disabled) ||
                           is_deleg_csr ||
                           is_next_csr;

  assign not_illegal = must_be_illegal && !illegal_raised;

  // ecall cause or anything of higher priority
  assign ecall_cause_ok = (trap_cause == isa_pkg::EXC_CAUSE_ECALL_UMODE) ||
                          (trap_cause == isa_pkg::EXC_CAUSE_ILLEGAL_INSN) ||
                          higher_cause;

  assign ecall_bad = is_ecall && in_u && (!trap_exception || !ecall_cause_ok);

endmodule

//--- hdl/mstatus_checker.sv
module mstatus_checker (
  input  logic [priv_pkg::MODE_W-1:0] retire_mode,
  input  logic [priv_pkg::XLEN-1:0]   mstatus_rdata,
  input  logic [priv_pkg::XLEN-1:0]   mstatus_wdata,
  input  logic [priv_pkg::XLEN-1:0]   mstatus_wmask,
  input  logic                        is_mret,
  input  logic                        trap_exception,
  output logic [priv_pkg::MODE_W-1:0] mpp_pre,
  output logic                        mstatus_bad,
  output logic                        mret_write_bad
);

  logic [priv_pkg::XLEN-1:0]   post;
  logic [priv_pkg::MODE_W-1:0] mpp_post;
  logic                        mpp_bad;
  logic                        ext_bad;
  logic                        mprv_in_u;

  // value left in mstatus after the retirement
  assign post = (mstatus_wdata & mstatus_wmask) | (mstatus_rdata & ~mstatus_wmask);

  assign mpp_pre  = mstatus_rdata[priv_pkg::MPP_POS +: priv_pkg::MPP_LEN];
  assign mpp_post = post[priv_pkg::MPP_POS +: priv_pkg::MPP_LEN];

  assign mpp_bad = (mpp_post != priv_pkg::MODE_M) && (mpp_post != priv_pkg::MODE_U);

  // no F, no custom extension state
  assign ext_bad = (|mstatus_rdata[priv_pkg::XS_POS +: priv_pkg::XS_LEN]) ||
                   (|mstatus_rdata[priv_pkg::FS_POS +: priv_pkg::FS_LEN]) ||
                   mstatus_rdata[priv_pkg::SD_POS];

  assign mprv_in_u = (retire_mode == priv_pkg::MODE_U) && mstatus_rdata[priv_pkg::MPRV_POS];

  assign mstatus_bad = mpp_bad || mstatus_rdata[priv_pkg::SPP_POS] || ext_bad || mprv_in_u;

  // mret drops mpp to U and clears mprv on return to U
  assign mret_write_bad = is_mret && !trap_exception &&
                          ((mpp_post != priv_pkg::MODE_U) ||
                           ((mpp_pre == priv_pkg::MODE_U) && post[priv_pkg::MPRV_POS]));

endmodule

//--- hdl/insn_decoder.sv
module insn_decoder (
  input  logic                          retire_valid,
  input  isa_pkg::sys_insn_t            retire_insn,
  input  logic [priv_pkg::MODE_W-1:0]   retire_mode,
  input  logic [priv_pkg::XLEN-1:0]     mcounteren_rdata,
  output logic                          is_mret,
  output logic                          is_wfi,
  output logic                          is_uret,
  output logic                          is_custom,
  output logic                          is_ecall,
  output logic                          is_csr,
  output logic                          csr_above_user,
  output logic                          is_counter_csr,
  output logic                          counter_disabled,
  output logic                          is_deleg_csr,
  output logic                          is_next_csr
);

  logic        system_op;
  logic        priv_form;
  logic [11:0] funct12;
  logic [31:0] insn_word;
  logic [11:0] csr_addr;
  logic [11:0] counter_off;

  assign insn_word = retire_insn;
  assign system_op = retire_valid && (retire_insn.sys.opcode == isa_pkg::SYSTEM_OPCODE);

  // mret, wfi, uret and ecall have rs1, funct3 and rd all zero
  assign priv_form = system_op && (retire_insn.sys.funct3 == 3'd0) &&
                     (retire_insn.sys.rs1 == 5'd0) && (retire_insn.sys.rd == 5'd0);
  assign funct12   = {retire_insn.sys.funct7, retire_insn.sys.rs2};

  assign is_mret  = priv_form && (funct12 == isa_pkg::MRET_IDATA[31:20]);
  assign is_wfi   = priv_form && (funct12 == isa_pkg::WFI_IDATA[31:20]);
  assign is_uret  = priv_form && (funct12 == isa_pkg::URET_IDATA[31:20]);
  assign is_ecall = priv_form && (funct12 == isa_pkg::ECALL_IDATA[31:20]);

  assign is_custom = system_op && (insn_word != isa_pkg::WFE_IDATA) &&
                     (((insn_word & isa_pkg::CUSTOM_IMASK) == isa_pkg::CUSTOM0_IDATA) ||
                      ((insn_word & isa_pkg::CUSTOM_IMASK) == isa_pkg::CUSTOM1_IDATA));

  assign is_csr = system_op && (retire_insn.csr.funct3 != 3'd0) &&
                  (retire_insn.csr.funct3 != 3'd4);

  assign csr_addr = {retire_insn.csr.csr_rw, retire_insn.csr.csr_priv,
                     retire_insn.csr.csr_index};
  assign csr_above_user = is_csr && (retire_insn.csr.csr_priv != priv_pkg::MODE_U);

  // wraps below HPM0, so one compare covers the range
  assign counter_off    = csr_addr - priv_pkg::CSRADDR_HPM0;
  assign is_counter_csr = is_csr && (counter_off < priv_pkg::HPM_COUNT);
  // mcounteren only gates access from U
  assign counter_disabled = is_counter_csr && (retire_mode == priv_pkg::MODE_U) &&
                            !mcounteren_rdata[counter_off[4:0]];

  assign is_deleg_csr = is_csr && ((csr_addr == priv_pkg::CSRADDR_MEDELEG) ||
                                   (csr_addr == priv_pkg::CSRADDR_MIDELEG));

  assign is_next_csr = is_csr && (csr_addr inside {
    priv_pkg::CSRADDR_USTATUS, priv_pkg::CSRADDR_UIE, priv_pkg::CSRADDR_UTVEC,
    priv_pkg::CSRADDR_USCRATCH, priv_pkg::CSRADDR_UEPC, priv_pkg::CSRADDR_UCAUSE,
    priv_pkg::CSRADDR_UTVAL, priv_pkg::CSRADDR_UIP});

endmodule

//--- hdl/isa_pkg.sv
package isa_pkg;

  localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;

  // fixed system encodings
  localparam logic [31:0] MRET_IDATA  = 32'h3020_0073;
  localparam logic [31:0] WFI_IDATA   = 32'h1050_0073;
  localparam logic [31:0] WFE_IDATA   = 32'h8C00_0073;
  localparam logic [31:0] URET_IDATA  = 32'h0020_0073;
  localparam logic [31:0] ECALL_IDATA = 32'h0000_0073;

  // custom system space, wfe lives inside custom0
  localparam logic [31:0] CUSTOM0_IDATA = 32'h8C00_0073;
  localparam logic [31:0] CUSTOM1_IDATA = 32'hCC00_0073;
  localparam logic [31:0] CUSTOM_IMASK  = 32'hFC00_707F;

  localparam int CAUSE_W = 6;

  localparam logic [CAUSE_W-1:0] EXC_CAUSE_INSTR_FAULT           = 6'd1;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ILLEGAL_INSN          = 6'd2;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ECALL_UMODE           = 6'd8;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_INSTR_BUS_FAULT       = 6'd24;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_INSTR_INTEGRITY_FAULT = 6'd25;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } sys_fields_t;

  // csr address split into rw, priv and index
  typedef struct packed {
    logic [1:0] csr_rw;
    logic [1:0] csr_priv;
    logic [7:0] csr_index;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } csr_fields_t;

  typedef union packed {
    sys_fields_t sys;
    csr_fields_t csr;
  } sys_insn_t;

endpackage

//--- hdl/priv_pkg.sv
package priv_pkg;

  localparam int XLEN   = 32;
  localparam int MODE_W = 2;

  // only M and U exist
  localparam logic [MODE_W-1:0] MODE_U = 2'b00;
  localparam logic [MODE_W-1:0] MODE_M = 2'b11;

  // mstatus field positions
  localparam int MPP_POS  = 11;
  localparam int MPP_LEN  = 2;
  localparam int SPP_POS  = 8;
  localparam int MPRV_POS = 17;
  localparam int TW_POS   = 21;
  localparam int XS_POS   = 15;
  localparam int XS_LEN   = 2;
  localparam int FS_POS   = 13;
  localparam int FS_LEN   = 2;
  localparam int SD_POS   = 31;

  // user counters, cycle up to hpmcounter30
  localparam logic [11:0] CSRADDR_HPM0 = 12'hC00;
  localparam int          HPM_COUNT    = 31;

  localparam logic [11:0] CSRADDR_MEDELEG = 12'h302;
  localparam logic [11:0] CSRADDR_MIDELEG = 12'h303;

  // N extension, not implemented
  localparam logic [11:0] CSRADDR_USTATUS  = 12'h000;
  localparam logic [11:0] CSRADDR_UIE      = 12'h004;
  localparam logic [11:0] CSRADDR_UTVEC    = 12'h005;
  localparam logic [11:0] CSRADDR_USCRATCH = 12'h040;
  localparam logic [11:0] CSRADDR_UEPC     = 12'h041;
  localparam logic [11:0] CSRADDR_UCAUSE   = 12'h042;
  localparam logic [11:0] CSRADDR_UTVAL    = 12'h043;
  localparam logic [11:0] CSRADDR_UIP      = 12'h044;

  // report bits
  localparam int FLAGS_W            = 8;
  localparam int FLAG_BAD_MODE      = 0;
  localparam int FLAG_RESET_MODE    = 1;
  localparam int FLAG_TRAP_TARGET   = 2;
  localparam int FLAG_MRET_TARGET   = 3;
  localparam int FLAG_MSTATUS_FIELD = 4;
  localparam int FLAG_MRET_WRITE    = 5;
  localparam int FLAG_NOT_ILLEGAL   = 6;
  localparam int FLAG_ECALL_CAUSE   = 7;

endpackage
